// File: hw/videoPkg.sv
// **********************************************************************
// Raster and video output types
// **********************************************************************

package videoPkg;

  // Active picture
  localparam int ACTIVE_W = 16;
  localparam int ACTIVE_H = 8;

  // Full frame including blanking
  localparam int TOTAL_W = 24;
  localparam int TOTAL_H = 12;

  // Sync placement
  localparam int HSYNC_START = 18;
  localparam int HSYNC_END   = 20; // Exclusive
  localparam int VSYNC_LINE  = 10;

  // Raster counter widths
  localparam int H_CNT_W = $clog2(TOTAL_W);
  localparam int V_CNT_W = $clog2(TOTAL_H);

  // One byte per active pixel
  localparam int FB_DEPTH  = ACTIVE_W * ACTIVE_H;
  localparam int FB_ADDR_W = 7;

  // Hue in the upper nibble, luminance in the lower
  typedef logic [7:0] colorByte_t;

  typedef struct packed {
    logic       de;
    logic       hsync;
    logic       vsync;
    colorByte_t color;
  } videoOut_t;

endpackage

// File: hw/colorRegPkg.sv
// **********************************************************************
// Colour register map and types
// **********************************************************************

package colorRegPkg;

  import videoPkg::*;

  localparam int REG_ADDR_W = 4;

  // Same offsets as the original chip
  localparam logic [REG_ADDR_W-1:0] ADDR_COLPF0 = 4'd6;
  localparam logic [REG_ADDR_W-1:0] ADDR_COLPF1 = 4'd7;
  localparam logic [REG_ADDR_W-1:0] ADDR_COLPF2 = 4'd8;
  localparam logic [REG_ADDR_W-1:0] ADDR_COLBK  = 4'd10;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] addr;
    logic [7:0]            data;
  } regWrite_t;

  typedef struct packed {
    colorByte_t bk;
    colorByte_t pf0;
    colorByte_t pf1;
    colorByte_t pf2;
  } colorBank_t;

  // Playfield code per pixel
  typedef logic [1:0] pfCode_t;

  localparam pfCode_t CODE_BK  = 2'd0;
  localparam pfCode_t CODE_PF0 = 2'd1;
  localparam pfCode_t CODE_PF1 = 2'd2;
  localparam pfCode_t CODE_PF2 = 2'd3;

endpackage

// File: hw/colorRegs.sv
// **********************************************************************
// Colour register bank
// **********************************************************************

`timescale 1ns/1ps

module colorRegs
  import colorRegPkg::*;
(
  input  logic       USER_CLK,
  input  logic       rst,
  input  logic       regWe,
  input  regWrite_t  regWr,
  output colorBank_t bank
);

  logic [7:0] wrData;

  // Luminance LSB is not stored on the real chip
  assign wrData = {regWr.data[7:1], 1'b0};

  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      bank <= '0;
    end else if (regWe) begin
      case (regWr.addr)
        ADDR_COLBK: begin
          bank.bk <= wrData;
        end
        ADDR_COLPF0: begin
          bank.pf0 <= wrData;
        end
        ADDR_COLPF1: begin
          bank.pf1 <= wrData;
        end
        ADDR_COLPF2: begin
          bank.pf2 <= wrData;
        end
        default: begin
          bank <= bank; // Unmapped address ignored
        end
      endcase
    end
  end

endmodule

// File: hw/colorResolver.sv
// **********************************************************************
// Playfield code to colour, buffer writer
// **********************************************************************

`timescale 1ns/1ps

module colorResolver
  import videoPkg::*;
  import colorRegPkg::*;
(
  input  logic                 USER_CLK,
  input  logic                 rst,
  input  logic                 pixWe,
  input  pfCode_t              pixCode,
  input  colorBank_t           bank,
  output logic                 fbWe,
  output logic [FB_ADDR_W-1:0] fbAddr,
  output colorByte_t           fbData
);

  logic [FB_ADDR_W-1:0] wrPtr;
  colorByte_t           pixColor;

  always_comb begin
    case (pixCode)
      CODE_PF0: pixColor = bank.pf0;
      CODE_PF1: pixColor = bank.pf1;
      CODE_PF2: pixColor = bank.pf2;
      default:  pixColor = bank.bk; // CODE_BK
    endcase
  end

  // Write pointer, one step per strobe
  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      wrPtr <= '0;
      fbWe  <= 1'b0;
    end else begin
      fbWe <= pixWe;
      if (pixWe) begin
        if (wrPtr == FB_ADDR_W'(FB_DEPTH - 1)) begin
          wrPtr <= '0;
        end else begin
          wrPtr <= wrPtr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge USER_CLK) begin
    if (pixWe) begin
      fbAddr <= wrPtr;
      fbData <= pixColor; // Bank as seen at this edge
    end
  end

endmodule

// File: hw/frameBuffer.sv
// **********************************************************************
// Frame buffer RAM
// **********************************************************************

`timescale 1ns/1ps

module frameBuffer
  import videoPkg::*;
(
  input  logic                 USER_CLK,
  input  logic                 we,
  input  logic [FB_ADDR_W-1:0] wAddr,
  input  colorByte_t           wData,
  input  logic [FB_ADDR_W-1:0] rAddr,
  output colorByte_t           rData
);

  colorByte_t mem [FB_DEPTH];

  // Read returns old data on an address collision
  always_ff @(posedge USER_CLK) begin
    if (we) begin
      mem[wAddr] <= wData;
    end
    rData <= mem[rAddr];
  end

endmodule

// File: hw/scanOut.sv
// **********************************************************************
// Raster timing and scan-out
// **********************************************************************

`timescale 1ns/1ps

module scanOut
  import videoPkg::*;
(
  input  logic                 USER_CLK,
  input  logic                 rst,
  output logic [FB_ADDR_W-1:0] rAddr,
  input  colorByte_t           rData,
  output videoOut_t            video
);

  logic [H_CNT_W-1:0] hCount;
  logic [V_CNT_W-1:0] vCount;
  logic               active;
  logic               hsyncNow;
  logic               vsyncNow;
  logic               deQ;
  logic               hsyncQ;
  logic               vsyncQ;

  // Raster counters
  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      hCount <= '0;
      vCount <= '0;
    end else if (hCount == H_CNT_W'(TOTAL_W - 1)) begin
      hCount <= '0;
      if (vCount == V_CNT_W'(TOTAL_H - 1)) begin
        vCount <= '0;
      end else begin
        vCount <= vCount + 1'b1;
      end
    end else begin
      hCount <= hCount + 1'b1;
    end
  end

  assign active = (hCount < H_CNT_W'(ACTIVE_W)) && (vCount < V_CNT_W'(ACTIVE_H));

  assign hsyncNow = (hCount >= H_CNT_W'(HSYNC_START)) && (hCount < H_CNT_W'(HSYNC_END));
  assign vsyncNow = (vCount == V_CNT_W'(VSYNC_LINE));

  // Line-major pixel address
  assign rAddr = active ? FB_ADDR_W'(vCount * ACTIVE_W + hCount) : '0;

  // Flags wait one cycle for the RAM read
  always_ff @(posedge USER_CLK or posedge rst) begin
    if (rst) begin
      deQ    <= 1'b0;
      hsyncQ <= 1'b0;
      vsyncQ <= 1'b0;
    end else begin
      deQ    <= active;
      hsyncQ <= hsyncNow;
      vsyncQ <= vsyncNow;
    end
  end

  always_comb begin
    video.de    = deQ;
    video.hsync = hsyncQ;
    video.vsync = vsyncQ;
    video.color = deQ ? rData : '0; // Black in blanking
  end

endmodule

// File: hw/display.sv
// **********************************************************************
// Playfield display top
// **********************************************************************

`timescale 1ns/1ps

module display
  import videoPkg::*;
  import colorRegPkg::*;
(
  input  logic      USER_CLK,
  input  logic      rst,
  input  logic      regWe,
  input  regWrite_t regWr,
  input  logic      pixWe,
  input  pfCode_t   pixCode,
  output videoOut_t video
);

  colorBank_t           bank;
  logic                 fbWe;
  logic [FB_ADDR_W-1:0] fbAddr;
  colorByte_t           fbData;
  logic [FB_ADDR_W-1:0] rAddr;
  colorByte_t           rData;

  colorRegs u_colorRegs (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .regWe    (regWe),
    .regWr    (regWr),
    .bank     (bank)
  );

  colorResolver u_colorResolver (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .pixWe    (pixWe),
    .pixCode  (pixCode),
    .bank     (bank),
    .fbWe     (fbWe),
    .fbAddr   (fbAddr),
    .fbData   (fbData)
  );

  frameBuffer u_frameBuffer (
    .USER_CLK (USER_CLK),
    .we       (fbWe),
    .wAddr    (fbAddr),
    .wData    (fbData),
    .rAddr    (rAddr),
    .rData    (rData)
  );

  scanOut u_scanOut (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .rAddr    (rAddr),
    .rData    (rData),
    .video    (video)
  );

endmodule

// File: verification/displayChecker.sv
// **********************************************************************
// Display reference model and output checker
// **********************************************************************

`timescale 1ns/1ps

module displayChecker
  import videoPkg::*;
  import colorRegPkg::*;
(
  input  logic      USER_CLK,
  input  logic      rst,
  input  logic      regWe,
  input  regWrite_t regWr,
  input  logic      pixWe,
  input  pfCode_t   pixCode,
  input  videoOut_t video,
  output int        errCount
);

  colorBank_t bankModel;
  colorByte_t memModel [FB_DEPTH];
  logic       memKnown [FB_DEPTH];
  int         ptrModel;
  logic       pendWe;
  int         pendAddr;
  colorByte_t pendData;
  videoOut_t  expVideo;
  logic       expKnown;
  logic       outValid = 1'b0;
  int         hPos;
  int         vPos;
  int         expH;
  int         expV;
  int         addr;
  int         frameDe;
  string      curName = "none";
  int         testErrs = 0;
  int         testsRun = 0;
  int         testsFailed = 0;

  initial begin
    errCount = 0;
    for (int i = 0; i < FB_DEPTH; i++) begin
      memKnown[i] = 1'b0; // RAM has no reset
    end
  end

  task startTest(input string name);
    curName  = name;
    testErrs = 0;
  endtask

  task finishTest();
    testsRun++;
    if (testErrs == 0) begin
      $display("PASS %s", curName);
    end else begin
      testsFailed++;
      $display("FAIL %s: %0d mismatches", curName, testErrs);
    end
  endtask

  task report();
    $display("Done: %0d tests, %0d failed, %0d mismatches in total",
             testsRun, testsFailed, errCount);
  endtask

  task automatic checkByte(input string what, input string where,
                           input logic [7:0] want, input logic [7:0] got);
    if (got !== want) begin
      $display("FAIL %s: %s %s expected %h actual %h", curName, what, where, want, got);
      testErrs++;
      errCount++;
    end
  endtask

  task automatic compareVideo(input videoOut_t want, input logic colorKnown,
                              input string where);
    checkByte("de", where, 8'(want.de), 8'(video.de));
    checkByte("hsync", where, 8'(want.hsync), 8'(video.hsync));
    checkByte("vsync", where, 8'(want.vsync), 8'(video.vsync));
    if (colorKnown) begin
      checkByte("color", where, want.color, video.color);
    end
  endtask

  function automatic colorByte_t pickColor(input colorBank_t b, input pfCode_t code);
    case (code)
      2'd1:    return b.pf0;
      2'd2:    return b.pf1;
      2'd3:    return b.pf2;
      default: return b.bk;
    endcase
  endfunction

  // Outputs read here still hold the values from before this edge
  always @(posedge USER_CLK) begin
    if (rst) begin
      compareVideo('0, 1'b1, "in reset");
      bankModel = '0;
      ptrModel  = 0;
      pendWe    = 1'b0;
      hPos      = 0;
      vPos      = 0;
      frameDe   = 0;
      outValid  = 1'b0;
    end else begin
      if (outValid) begin
        compareVideo(expVideo, expKnown, $sformatf("at (%0d,%0d)", expH, expV));
        if (video.de === 1'b1) begin
          frameDe++;
        end
        if (expH == TOTAL_W - 1 && expV == TOTAL_H - 1) begin
          if (frameDe != FB_DEPTH) begin
            $display("FAIL %s: de cycles per frame expected %0d actual %0d",
                     curName, FB_DEPTH, frameDe);
            testErrs++;
            errCount++;
          end
          frameDe = 0;
        end
      end else begin
        compareVideo('0, 1'b1, "one cycle after reset");
      end

      // Shown one cycle later, read before this edge's write
      expH           = hPos;
      expV           = vPos;
      expVideo.de    = (hPos < ACTIVE_W) && (vPos < ACTIVE_H);
      expVideo.hsync = (hPos >= HSYNC_START) && (hPos < HSYNC_END);
      expVideo.vsync = (vPos == VSYNC_LINE);
      expVideo.color = '0;
      expKnown       = 1'b1;
      if (expVideo.de) begin
        addr           = vPos * ACTIVE_W + hPos;
        expVideo.color = memModel[addr];
        expKnown       = memKnown[addr];
      end

      hPos++;
      if (hPos == TOTAL_W) begin
        hPos = 0;
        vPos = (vPos + 1) % TOTAL_H;
      end

      if (pendWe) begin // Strobe from last edge reaches the RAM
        memModel[pendAddr] = pendData;
        memKnown[pendAddr] = 1'b1;
      end
      pendWe = pixWe;
      if (pixWe) begin
        pendAddr = ptrModel;
        pendData = pickColor(bankModel, pixCode);
        ptrModel = (ptrModel + 1) % FB_DEPTH;
      end

      if (regWe) begin
        case (regWr.addr)
          ADDR_COLBK:  bankModel.bk  = regWr.data & 8'hFE;
          ADDR_COLPF0: bankModel.pf0 = regWr.data & 8'hFE;
          ADDR_COLPF1: bankModel.pf1 = regWr.data & 8'hFE;
          ADDR_COLPF2: bankModel.pf2 = regWr.data & 8'hFE;
          default: ;
        endcase
      end
      outValid = 1'b1;
    end
  end

endmodule

// File: verification/displayTb.sv
// **********************************************************************
// Playfield display testbench
// **********************************************************************

`timescale 1ns/1ps

module displayTb
  import videoPkg::*;
  import colorRegPkg::*;
();

  typedef struct packed {
    colorByte_t bk;
    colorByte_t pf0;
    colorByte_t pf1;
    colorByte_t pf2;
    logic [7:0] strobes;
    logic       useLfsr;
    pfCode_t    code;
  } testEntry_t;

  logic        USER_CLK = 1'b1; // First edge falls
  logic        rst;
  logic        regWe;
  regWrite_t   regWr;
  logic        pixWe;
  pfCode_t     pixCode;
  videoOut_t   video;
  logic        vsyncOut;
  int          errCount;

  testEntry_t  tests [5];
  string       names [5];
  logic [15:0] lfsrState;
  int          cycleCount = 0;
  int          cycleLimit;

  assign vsyncOut = video.vsync;

  always #10 USER_CLK = ~USER_CLK;

  display u_dut (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .regWe    (regWe),
    .regWr    (regWr),
    .pixWe    (pixWe),
    .pixCode  (pixCode),
    .video    (video)
  );

  displayChecker u_check (
    .USER_CLK (USER_CLK),
    .rst      (rst),
    .regWe    (regWe),
    .regWr    (regWr),
    .pixWe    (pixWe),
    .pixCode  (pixCode),
    .video    (video),
    .errCount (errCount)
  );

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic takeCode(output pfCode_t code);
    code[0]   = lfsrState[0];
    lfsrState = lfsrStep(lfsrState);
    code[1]   = lfsrState[0];
    lfsrState = lfsrStep(lfsrState);
  endtask

  // Cycle 3 hits an unmapped address and cycle 4 lands with the first strobe
  function automatic regWrite_t regWriteAt(input testEntry_t t, input int c);
    regWrite_t w;
    case (c)
      0:       w = {ADDR_COLBK, t.bk};
      1:       w = {ADDR_COLPF0, t.pf0};
      2:       w = {ADDR_COLPF1, t.pf1};
      3:       w = {4'd9, ~t.bk};
      default: w = {ADDR_COLPF2, t.pf2};
    endcase
    return w;
  endfunction

  task automatic fillTests();
    tests[0] = {8'h11, 8'h35, 8'h47, 8'hC9, 8'd128, 1'b0, CODE_PF1};
    names[0] = "fixedCodePf1";
    tests[1] = {8'h5B, 8'h23, 8'h87, 8'hE1, 8'd128, 1'b0, CODE_BK};
    names[1] = "fixedCodeBk";
    tests[2] = {8'h0F, 8'h3D, 8'h6B, 8'hA5, 8'd128, 1'b1, CODE_BK};
    names[2] = "lfsrFrame";
    tests[3] = {8'hF3, 8'h71, 8'h2F, 8'h9D, 8'd0, 1'b0, CODE_BK}; // Frame must hold
    names[3] = "regChangeHold";
    tests[4] = {8'h45, 8'hB7, 8'hD9, 8'h63, 8'd130, 1'b1, CODE_BK};
    names[4] = "lfsrWrap";
  endtask

  task automatic runTest(input testEntry_t t);
    int cycles;
    cycles = (t.strobes + 4 > 5) ? t.strobes + 4 : 5;
    for (int c = 0; c < cycles; c++) begin
      @(negedge USER_CLK);
      regWe = 1'b0;
      pixWe = 1'b0;
      if (c < 5) begin
        regWe = 1'b1;
        regWr = regWriteAt(t, c);
      end
      if (c >= 4 && c - 4 < t.strobes) begin
        pixWe = 1'b1;
        if (t.useLfsr) begin
          takeCode(pixCode);
        end else begin
          pixCode = t.code;
        end
      end
    end
    @(negedge USER_CLK);
    regWe = 1'b0;
    pixWe = 1'b0;
    // Second vsync means a whole frame was scanned after the last write
    repeat (2) @(posedge vsyncOut);
  endtask

  always @(posedge USER_CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    rst       = 1'b0;
    regWe     = 1'b0;
    regWr     = '0;
    pixWe     = 1'b0;
    pixCode   = '0;
    lfsrState = 16'd2692;
    fillTests();
    cycleLimit = 1 + 16 + 2 + 200; // Reset plus margin
    for (int i = 0; i < $size(tests); i++) begin
      cycleLimit += tests[i].strobes + 5 + 3 * TOTAL_W * TOTAL_H;
    end
    u_check.startTest("reset");
    @(negedge USER_CLK);
    rst = 1'b1;
    repeat (16) @(negedge USER_CLK);
    rst = 1'b0;
    repeat (2) @(negedge USER_CLK);
    u_check.finishTest();
    for (int i = 0; i < $size(tests); i++) begin
      u_check.startTest(names[i]);
      runTest(tests[i]);
      u_check.finishTest();
    end
    u_check.report();
    if (errCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: display.f
hw/videoPkg.sv
hw/colorRegPkg.sv
hw/colorRegs.sv
hw/colorResolver.sv
hw/frameBuffer.sv
hw/scanOut.sv
hw/display.sv
verification/displayChecker.sv
verification/displayTb.sv

// File: Bender.yml
package:
  name: display

sources:
  - hw/videoPkg.sv
  - hw/colorRegPkg.sv
  - hw/colorRegs.sv
  - hw/colorResolver.sv
  - hw/frameBuffer.sv
  - hw/scanOut.sv
  - hw/display.sv
  - target: test
    files:
      - verification/displayChecker.sv
      - verification/displayTb.sv
